/* Makefile */
# Verilator build and run for the branch unit testbench

TOP := branchUnitTb

.PHONY: all lint clean

# Build, run, and pass only if the pass line shows up
all:
	verilator --binary --timing --assert -j 0 -f sim.f --top-module $(TOP) -Mdir obj_dir -o simv
	./obj_dir/simv | awk '{ print } /^TB PASSED$$/ { ok = 1 } END { exit !ok }'

lint:
	verilator --lint-only --timing -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir

/* design/branchCond.sv */
// ########################################
// Branch condition checker, one cycle after the strobe
// Produces taken and delay-slot flags plus a result strobe
// ########################################
`default_nettype none

`include "branchMacros.svh"

module branchCond import isaPkg::*, branchPkg::*; (
   input  logic                    gclk,
   input  logic                    grst,
   input  logic                    instValid,
   input  brKind                   kind,
   input  brCond                   cond,
   input  logic                    delayFlag,
   input  logic [`DATA_WIDTH-1:0]  valA,
   output logic                    branchTaken,
   output logic                    delaySlot,
   output logic                    resultValid
);

   logic isZero;
   logic isNeg;
   logic condMet;
   logic takeNow;

   assign isZero = (valA == '0);
   assign isNeg  = valA[`DATA_WIDTH-1];   // Sign bit

   // Condition table against zero
   always_comb begin
      case (cond)
         condEq:  condMet = isZero;
         condNe:  condMet = !isZero;
         condLt:  condMet = isNeg;
         condLe:  condMet = isNeg || isZero;
         condGt:  condMet = !(isNeg || isZero);
         condGe:  condMet = !isNeg;
         default: condMet = 1'b0;         // Illegal codes never taken
      endcase
   end

   // Jumps and returns always go
   assign takeNow = (kind == kindUncond) || (kind == kindReturn) ||
                    ((kind == kindCond) && condMet);

   always_ff @(posedge gclk) begin
      if (grst) begin
         resultValid <= 1'b0;
         branchTaken <= 1'b0;
         delaySlot   <= 1'b0;
      end else begin
         resultValid <= instValid;        // One-cycle pulse
         if (instValid) begin
            branchTaken <= takeNow;
            delaySlot   <= isBranch(kind) && delayFlag;
         end                              // Else hold last result
      end
   end

   // Decode must never hand over codes 6 or 7 on a strobed bcc
   legalCond: assert property (
      @(posedge gclk) disable iff (grst)
      (instValid && (kind == kindCond)) |-> (cond <= condGe)
   ) else $error("Illegal branch condition code %0d", cond);

endmodule

`default_nettype wire

/* design/branchMacros.svh */
// ########################################
// Width and register-count macros for the branch slice
// Included by packages and RTL that size buses or the register file
// ########################################
`ifndef BRANCH_MACROS_SVH
`define BRANCH_MACROS_SVH

// Data path and PC width
`define DATA_WIDTH 32

// Architectural register count, r0 included
`define REG_COUNT 32

// Register address field width
`define REG_ADDR_WIDTH 5

`endif

/* design/branchPkg.sv */
// ########################################
// Branch classification shared by decode, condition and target
// ########################################
`default_nettype none

package branchPkg;

   // What decode made of the opcode
   typedef enum logic [1:0] {
      kindNone   = 2'd0,  // Not a branch, never taken
      kindUncond = 2'd1,  // bru / brui, may be absolute
      kindCond   = 2'd2,  // bcc / bcci, condition on ra
      kindReturn = 2'd3   // rtd, target is ra plus imm
   } brKind;

   // Helper for the checker and target unit
   function automatic logic isBranch(brKind k);
      return k != kindNone;
   endfunction

endpackage

`default_nettype wire

/* design/branchTarget.sv */
// ########################################
// Branch target adder, registered on the instruction strobe
// Base is pc, ra or zero, operand is imm or rb
// ########################################
`default_nettype none

`include "branchMacros.svh"

module branchTarget import branchPkg::*; (
   input  logic                    gclk,
   input  logic                    grst,
   input  logic                    instValid,
   input  brKind                   kind,
   input  logic                    useImm,
   input  logic                    absolute,
   input  logic [`DATA_WIDTH-1:0]  imm,
   input  logic [`DATA_WIDTH-1:0]  pc,
   input  logic [`DATA_WIDTH-1:0]  valA,
   input  logic [`DATA_WIDTH-1:0]  valB,
   output logic [`DATA_WIDTH-1:0]  branchTargetAddr
);

   logic [`DATA_WIDTH-1:0] operand;
   logic [`DATA_WIDTH-1:0] base;
   logic [`DATA_WIDTH-1:0] sum;

   // Offset source
   assign operand = useImm ? imm : valB;

   // Base select
   always_comb begin
      if (kind == kindReturn) begin
         base = valA;                      // rtd jumps relative to ra
      end else if ((kind == kindUncond) && absolute) begin
         base = '0;                        // Operand is the target
      end else begin
         base = pc;                        // PC-relative
      end
   end

   assign sum = base + operand;           // Wraps, no carry out

   always_ff @(posedge gclk) begin
      if (grst) begin
         branchTargetAddr <= '0;
      end else if (instValid) begin
         branchTargetAddr <= sum;
      end
   end

endmodule

`default_nettype wire

/* design/branchUnit.sv */
// ########################################
// Branch resolution top, one cycle from strobe to decision
// Joins decode, register file, condition checker and target adder
// ########################################
`default_nettype none

`include "branchMacros.svh"

module branchUnit import isaPkg::*, branchPkg::*; (
   input  logic                        gclk,
   input  logic                        grst,
   input  logic                        instValid,
   input  instWord                     inst,
   input  logic [`DATA_WIDTH-1:0]      pc,
   input  logic                        wrEn,
   input  logic [`REG_ADDR_WIDTH-1:0]  wrAddr,
   input  logic [`DATA_WIDTH-1:0]      wrData,
   output logic                        branchTaken,
   output logic                        delaySlot,
   output logic [`DATA_WIDTH-1:0]      branchTargetAddr,
   output logic                        resultValid
);

   logic [`REG_ADDR_WIDTH-1:0] regA;
   logic [`REG_ADDR_WIDTH-1:0] regB;
   brKind                      kind;
   brCond                      cond;
   logic                       delayFlag;
   logic                       useImm;
   logic                       absolute;
   logic [`DATA_WIDTH-1:0]     imm;
   logic [`DATA_WIDTH-1:0]     valA;
   logic [`DATA_WIDTH-1:0]     valB;

   instDecode iDecode (              // Pure combinational
      .inst(inst), .regA(regA), .regB(regB), .kind(kind), .cond(cond),
      .delayFlag(delayFlag), .useImm(useImm), .absolute(absolute), .imm(imm)
   );

   regFile iRegFile (
      .gclk(gclk), .grst(grst), .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
      .regA(regA), .regB(regB), .valA(valA), .valB(valB)
   );

   // Decision path
   branchCond iCond (
      .gclk(gclk), .grst(grst), .instValid(instValid), .kind(kind),
      .cond(cond), .delayFlag(delayFlag), .valA(valA),
      .branchTaken(branchTaken), .delaySlot(delaySlot), .resultValid(resultValid)
   );

   // Address path, same latency as the decision
   branchTarget iTarget (
      .gclk(gclk), .grst(grst), .instValid(instValid), .kind(kind),
      .useImm(useImm), .absolute(absolute), .imm(imm), .pc(pc),
      .valA(valA), .valB(valB), .branchTargetAddr(branchTargetAddr)
   );

endmodule

`default_nettype wire

/* design/instDecode.sv */
// ########################################
// Combinational branch decode of one instruction word
// Feeds register addresses, kind and immediate to the branch unit
// ########################################
`default_nettype none

`include "branchMacros.svh"

module instDecode import isaPkg::*, branchPkg::*; (
   input  instWord                     inst,
   output logic [`REG_ADDR_WIDTH-1:0]  regA,
   output logic [`REG_ADDR_WIDTH-1:0]  regB,
   output brKind                       kind,
   output brCond                       cond,
   output logic                        delayFlag,
   output logic                        useImm,
   output logic                        absolute,
   output logic [`DATA_WIDTH-1:0]      imm
);

   logic [5:0]  opcode;
   logic [15:0] immField;

   assign opcode   = inst.typeA.opcode;
   assign immField = inst.typeB.imm;       // Immediate view of the word

   // Register operands
   assign regA = inst.typeA.ra;
   assign regB = inst.typeA.rb;            // Only meaningful in register form

   // Opcode classification
   always_comb begin
      case (opcode)
         opBru, opBrui: kind = kindUncond;
         opBcc, opBcci: kind = kindCond;
         opRtd:         kind = kindReturn;
         default:       kind = kindNone;  // Everything else falls through
      endcase
   end

   // Condition code in rd low bits
   assign cond = brCond'(inst.typeA.rd[2:0]);

   // Delay bit lives in rd for bcc, in ra otherwise
   assign delayFlag = (kind == kindCond) ? inst.typeA.rd[4] : inst.typeA.ra[4];

   // Immediate form select
   assign useImm = opcode[3];

   // Absolute jump only for bru family
   assign absolute = (kind == kindUncond) && inst.typeA.ra[3];

   // Sign extend to data width
   assign imm = {{(`DATA_WIDTH-16){immField[15]}}, immField};

endmodule

`default_nettype wire

/* design/isaPkg.sv */
// ########################################
// Instruction word formats, branch opcodes and condition codes
// Imported by the decoder and the condition checker
// ########################################
`default_nettype none

`include "branchMacros.svh"

package isaPkg;

   // Register-register form
   typedef struct packed {
      logic [5:0]                  opcode;
      logic [`REG_ADDR_WIDTH-1:0]  rd;     // Condition code sits in low bits for bcc
      logic [`REG_ADDR_WIDTH-1:0]  ra;
      logic [`REG_ADDR_WIDTH-1:0]  rb;
      logic [10:0]                 func;
   } typeAFmt;

   // Register-immediate form
   typedef struct packed {
      logic [5:0]                  opcode;
      logic [`REG_ADDR_WIDTH-1:0]  rd;
      logic [`REG_ADDR_WIDTH-1:0]  ra;
      logic [15:0]                 imm;    // Sign-extended by decode
   } typeBFmt;

   // Same 32-bit word, two views
   typedef union packed {
      typeAFmt typeA;
      typeBFmt typeB;
   } instWord;

   // Branch opcodes, bit 3 set means immediate form
   localparam logic [5:0] opBru  = 6'o46;
   localparam logic [5:0] opBrui = 6'o56;
   localparam logic [5:0] opBcc  = 6'o47;
   localparam logic [5:0] opBcci = 6'o57;
   localparam logic [5:0] opRtd  = 6'o55;  // Return, immediate only

   // Conditions tested against ra, codes 6 and 7 illegal
   typedef enum logic [2:0] {
      condEq = 3'd0,
      condNe = 3'd1,
      condLt = 3'd2,
      condLe = 3'd3,
      condGt = 3'd4,
      condGe = 3'd5
   } brCond;

endpackage

`default_nettype wire

/* design/regFile.sv */
// ########################################
// 32-entry register file, two async reads, one sync write
// r0 is cleared on reset and never written
// ########################################
`default_nettype none

`include "branchMacros.svh"

module regFile (
   input  logic                        gclk,
   input  logic                        grst,
   input  logic                        wrEn,
   input  logic [`REG_ADDR_WIDTH-1:0]  wrAddr,
   input  logic [`DATA_WIDTH-1:0]      wrData,
   input  logic [`REG_ADDR_WIDTH-1:0]  regA,
   input  logic [`REG_ADDR_WIDTH-1:0]  regB,
   output logic [`DATA_WIDTH-1:0]      valA,
   output logic [`DATA_WIDTH-1:0]      valB
);

   // r0 included, held at zero by the write guard
   logic [`DATA_WIDTH-1:0] regs [0:`REG_COUNT-1];

   always_ff @(posedge gclk) begin
      if (grst) begin
         for (int i = 0; i < `REG_COUNT; i++) begin
            regs[i] <= '0;                  // Clear all on reset
         end
      end else if (wrEn && (wrAddr != '0)) begin
         regs[wrAddr] <= wrData;            // r0 writes dropped
      end
   end

   // Reads see pre-edge contents
   assign valA = regs[regA];
   assign valB = regs[regB];

   // A write aimed at r0 must not show up on a later read
   r0StaysZero: assert property (
      @(posedge gclk) disable iff (grst)
      (wrEn && (wrAddr == '0)) |=> ((regA != '0) || (valA == '0)) &&
                                   ((regB != '0) || (valB == '0))
   ) else $error("r0 read back nonzero after write to r0");

endmodule

`default_nettype wire

/* sim.f */
+incdir+design
design/isaPkg.sv
design/branchPkg.sv
design/instDecode.sv
design/regFile.sv
design/branchCond.sv
design/branchTarget.sv
design/branchUnit.sv
sim/branchUnitTb.sv

/* sim/branchUnitTb.sv */
// ########################################
// Self-checking testbench for the branch unit top level
// Shadow register file feeds a reference model, results checked on resultValid
// ########################################
`default_nettype none

`include "branchMacros.svh"

module branchUnitTb import isaPkg::*, branchPkg::*; ();

   localparam int TimeoutCycles = 50;     // Per wait loop
   localparam int RandomCycles  = 400;

   // One predicted result per strobe
   typedef struct packed {
      brKind                   kind;
      logic                    taken;
      logic                    delay;
      logic [`DATA_WIDTH-1:0]  target;
   } expResult;

   logic                        gclk;
   logic                        grst;
   logic                        instValid;
   instWord                     inst;
   logic [`DATA_WIDTH-1:0]      pc;
   logic                        wrEn;
   logic [`REG_ADDR_WIDTH-1:0]  wrAddr;
   logic [`DATA_WIDTH-1:0]      wrData;
   logic                        branchTaken;
   logic                        delaySlot;
   logic [`DATA_WIDTH-1:0]      branchTargetAddr;
   logic                        resultValid;

   logic [`DATA_WIDTH-1:0] shadow [0:`REG_COUNT-1];   // Mirror of the DUT registers
   expResult               expQ [$];
   integer                 seed;
   int                     errorCount;                // Compare process only
   int                     timeoutCount;              // Main process only
   int                     checkCount;
   int                     testErrStart;
   logic                   prevStrobe;
   logic                   wasReset;

   branchUnit i_dut (
      .gclk(gclk), .grst(grst), .instValid(instValid), .inst(inst), .pc(pc),
      .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
      .branchTaken(branchTaken), .delaySlot(delaySlot),
      .branchTargetAddr(branchTargetAddr), .resultValid(resultValid)
   );

   initial begin
      gclk = 1'b0;
      forever #2 gclk = ~gclk;            // Period 4
   end

   // Expected decision and target straight from the ISA rules
   function automatic expResult predictBranch(instWord w, logic [`DATA_WIDTH-1:0] p);
      expResult               r;
      logic [5:0]             op;
      logic [`DATA_WIDTH-1:0] a;
      logic [`DATA_WIDTH-1:0] opnd;
      logic                   hold;
      op = w.typeB.opcode;
      a  = shadow[w.typeB.ra];
      if (op[3]) begin
         opnd = {{(`DATA_WIDTH-16){w.typeB.imm[15]}}, w.typeB.imm};
      end else begin
         opnd = shadow[w.typeA.rb];
      end
      if (op == opBru || op == opBrui) r.kind = kindUncond;
      else if (op == opBcc || op == opBcci) r.kind = kindCond;
      else if (op == opRtd) r.kind = kindReturn;
      else r.kind = kindNone;
      // Signed test of ra against zero
      case (w.typeA.rd[2:0])
         3'd0:    hold = (a == '0);
         3'd1:    hold = (a != '0);
         3'd2:    hold = ($signed(a) < 0);
         3'd3:    hold = ($signed(a) <= 0);
         3'd4:    hold = ($signed(a) > 0);
         3'd5:    hold = ($signed(a) >= 0);
         default: hold = 1'b0;
      endcase
      r.taken = (r.kind == kindUncond) || (r.kind == kindReturn) ||
                ((r.kind == kindCond) && hold);
      if (r.kind == kindNone) r.delay = 1'b0;
      else if (r.kind == kindCond) r.delay = w.typeA.rd[4];
      else r.delay = w.typeA.ra[4];
      if (r.kind == kindReturn) r.target = a + opnd;
      else if (r.kind == kindUncond && w.typeA.ra[3]) r.target = opnd;   // Absolute jump
      else r.target = p + opnd;
      return r;
   endfunction

   task automatic checkDecision(input logic taken, input logic delay, input expResult e,
                                input string tag);
      checkCount++;
      if (taken !== e.taken || delay !== e.delay) begin
         errorCount++;
         $display("MISMATCH at %0t: %s %s taken %b delay %b, expected taken %b delay %b",
                  $time, tag, e.kind.name(), taken, delay, e.taken, e.delay);
      end
   endtask

   task automatic checkTarget(input logic [`DATA_WIDTH-1:0] got,
                              input logic [`DATA_WIDTH-1:0] exp, input string tag);
      checkCount++;
      if (got !== exp) begin
         errorCount++;
         $display("MISMATCH at %0t: %s target %h, expected %h", $time, tag, got, exp);
      end
   endtask

   // Outputs sampled mid-cycle, away from the driving edge
   always @(negedge gclk) begin : compareResults
      expResult e;
      expResult idle;
      idle = '0;
      if (grst) begin
         prevStrobe = 1'b0;
      end else begin
         if (wasReset) begin                // First look after reset
            checkDecision(branchTaken, delaySlot, idle, "after reset");
            checkTarget(branchTargetAddr, '0, "after reset");
         end
         if (resultValid !== prevStrobe) begin
            errorCount++;
            $display("MISMATCH at %0t: resultValid %b, expected %b",
                     $time, resultValid, prevStrobe);
         end
         if (resultValid === 1'b1) begin
            if (expQ.size() == 0) begin
               errorCount++;
               $display("ERROR at %0t: resultValid pulsed with nothing outstanding", $time);
            end else begin
               e = expQ.pop_front();
               checkDecision(branchTaken, delaySlot, e, "decision");
               if (e.kind != kindNone) checkTarget(branchTargetAddr, e.target, "branch");
            end
         end
         prevStrobe = instValid;           // Seen by the DUT at the next edge
      end
      wasReset = grst;
   end

   function automatic instWord makeImmInst(logic [5:0] op, logic [4:0] rd, logic [4:0] ra,
                                           logic [15:0] imm);
      instWord w;
      w.typeB.opcode = op;
      w.typeB.rd     = rd;
      w.typeB.ra     = ra;
      w.typeB.imm    = imm;
      return w;
   endfunction

   function automatic instWord makeRegInst(logic [5:0] op, logic [4:0] rd, logic [4:0] ra,
                                           logic [4:0] rb);
      instWord w;
      w.typeA.opcode = op;
      w.typeA.rd     = rd;
      w.typeA.ra     = ra;
      w.typeA.rb     = rb;
      w.typeA.func   = '0;
      return w;
   endfunction

   // One clock of stimulus, prediction taken before this cycle's write lands
   task automatic driveCycle(input logic strobe, input instWord w,
                             input logic [`DATA_WIDTH-1:0] p, input logic we,
                             input logic [`REG_ADDR_WIDTH-1:0] wa,
                             input logic [`DATA_WIDTH-1:0] wd);
      @(posedge gclk);
      if (strobe) expQ.push_back(predictBranch(w, p));
      instValid <= strobe;
      inst      <= w;
      pc        <= p;
      wrEn      <= we;
      wrAddr    <= wa;
      wrData    <= wd;
      if (we && wa != '0) shadow[wa] = wd;   // r0 never changes
   endtask

   task automatic issueInst(input instWord w, input logic [`DATA_WIDTH-1:0] p);
      driveCycle(1'b1, w, p, 1'b0, '0, '0);
   endtask

   task automatic writeReg(input logic [4:0] a, input logic [`DATA_WIDTH-1:0] d);
      driveCycle(1'b0, '0, '0, 1'b1, a, d);
   endtask

   // Go idle, wait for all results, report the test
   task automatic endTest(input string name);
      int waited;
      int errs;
      driveCycle(1'b0, '0, '0, 1'b0, '0, '0);
      waited = 0;
      while (expQ.size() != 0 && waited < TimeoutCycles) begin
         @(negedge gclk);
         waited++;
      end
      if (expQ.size() != 0) begin
         timeoutCount++;
         $display("ERROR: test %s timed out, %0d results never arrived", name, expQ.size());
         expQ.delete();
      end
      errs = errorCount + timeoutCount - testErrStart;
      $display("Test %-12s done, %0d errors", name, errs);
      testErrStart = errorCount + timeoutCount;
   endtask

   initial begin
      logic [5:0]             op;
      logic [4:0]             rdF;
      logic [4:0]             raF;
      logic [4:0]             rbF;
      logic [4:0]             wa;
      logic [15:0]            immF;
      logic [31:0]            rnd;
      logic [`DATA_WIDTH-1:0] p;
      logic [`DATA_WIDTH-1:0] wd;
      logic                   strobe;
      logic                   we;
      instWord                w;
      logic [5:0]             nonBranch [0:5];
      nonBranch = '{6'o00, 6'o12, 6'o44, 6'o54, 6'o66, 6'o77};
      seed = 32'h07947041;
      errorCount = 0;
      timeoutCount = 0;
      checkCount = 0;
      testErrStart = 0;
      prevStrobe = 1'b0;
      wasReset = 1'b0;
      for (int i = 0; i < `REG_COUNT; i++) shadow[i] = '0;   // Reset clears all
      grst = 1'b1;
      instValid = 1'b0;
      inst = '0;
      pc = '0;
      wrEn = 1'b0;
      wrAddr = '0;
      wrData = '0;
      repeat (4) @(posedge gclk);
      grst <= 1'b0;

      @(negedge gclk);                     // Reset state checked by compare process
      endTest("reset");

      // r1 zero, r2 negative, r3 positive, r4 offset
      writeReg(5'd1, 32'd0);
      writeReg(5'd2, 32'hFFFF_FFFB);
      writeReg(5'd3, 32'd7);
      writeReg(5'd4, 32'h0000_0100);
      for (int c = 0; c < 6; c++) begin
         for (int r = 0; r < 4; r++) begin
            issueInst(makeImmInst(opBcci, {c[0] ^ r[0], 1'b0, c[2:0]}, r[4:0], 16'hFFF0),
                      32'h1000 + c * 64 + r * 4);
            issueInst(makeRegInst(opBcc, {r[0], 1'b1, c[2:0]}, r[4:0], 5'd4),
                      32'h1800 + c * 64 + r * 4);
         end
      end
      endTest("conditional");

      // ra bit 4 delay, bit 3 absolute
      for (int r = 0; r < 4; r++) begin
         issueInst(makeImmInst(opBrui, 5'd0, {r[1:0], 3'b000}, 16'h0040), 32'h2000);
         issueInst(makeImmInst(opBrui, 5'd7, {r[1:0], 3'b000}, 16'h8004), 32'h2100);
         issueInst(makeRegInst(opBru, 5'd0, {r[1:0], 3'b001}, 5'd4), 32'h2200);
      end
      endTest("unconditional");

      writeReg(5'd17, 32'h0000_3000);      // Delay bit set via ra
      issueInst(makeImmInst(opRtd, 5'd0, 5'd3, 16'h0010), 32'h4000);
      issueInst(makeImmInst(opRtd, 5'd0, 5'd17, 16'hFFFC), 32'h4004);
      issueInst(makeImmInst(opRtd, 5'd16, 5'd2, 16'h0020), 32'h4008);
      issueInst(makeImmInst(opRtd, 5'd0, 5'd0, 16'h7FFC), 32'h400C);
      endTest("return");

      foreach (nonBranch[i]) begin
         issueInst(makeImmInst(nonBranch[i], 5'b11111, 5'b11000, 16'h1234), 32'h5000);
      end
      endTest("non-branch");

      for (int n = 0; n < RandomCycles; n++) begin
         rnd = $random(seed);
         case (rnd[2:0])
            3'd0, 3'd5: op = opBcc;
            3'd1, 3'd6: op = opBcci;
            3'd2:       op = opBru;
            3'd3:       op = opBrui;
            default:    op = opRtd;
         endcase
         rnd = $random(seed);
         rdF = rnd[4:0];
         raF = (n % 7 == 0) ? 5'd0 : rnd[9:5];   // r0 read now and then
         rbF = rnd[14:10];
         immF = rnd[31:16];
         if (op == opBcc || op == opBcci) begin
            rnd = $random(seed);
            rdF[2:0] = 3'(rnd % 6);        // Legal codes only
         end
         w = op[3] ? makeImmInst(op, rdF, raF, immF) : makeRegInst(op, rdF, raF, rbF);
         rnd = $random(seed);
         strobe = (rnd[1:0] != 2'b00);
         we = rnd[2];
         wa = (n % 5 == 0) ? 5'd0 : rnd[7:3];    // Some writes aimed at r0
         p = $random(seed);
         wd = $random(seed);
         driveCycle(strobe, w, p, we, wa, wd);
      end
      endTest("random");

      $display("Summary: %0d checks, %0d errors", checkCount, errorCount + timeoutCount);
      if (errorCount + timeoutCount == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
